// File: rtl/apb_uart.sv
`include "uart_cfg.svh"

module apb_uart (
	input  logic                        apb,
	input  logic                        rst,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [`UART_ADDR_WIDTH-1:0] paddr,
	input  logic [`UART_DATA_WIDTH-1:0] pwdata,
	output logic [`UART_DATA_WIDTH-1:0] prdata,
	output logic                        pready,
	output logic                        pslverr,
	input  logic                        rx,
	output logic                        tx
);

	import uart_pkg::*;

	logic [15:0] clk_div;
	logic        overrun;
	logic        addr_ok;
	reg_index_t  reg_sel;
	logic        access;

	// TX side
	logic       tx_wr;
	logic       tx_rd;
	uart_byte_t tx_dout;
	logic       tx_empty;
	logic       tx_full;
	logic       tx_busy;
	logic       tx_start;
	logic       tx_done;

	// RX side
	logic      rx_valid;
	rx_entry_t rx_entry;
	logic      rx_rd;
	rx_entry_t rx_dout;
	logic      rx_empty;
	logic      rx_full;
	logic      rx_empty_q;

	////////////////////
	// Address decode

	// Only the four words at the bottom are mapped
	assign addr_ok = paddr[`UART_ADDR_WIDTH-1:4] == '0;
	assign reg_sel = reg_index_t'(paddr[3:2]);

	// First access cycle, before the wait state ends
	assign access = psel && penable && !pready;

	// One wait state on every transfer
	always_ff @(posedge apb) begin
		if (rst)
			pready <= 1'b0;
		else
			pready <= access;
	end

	////////////////////
	// Transmit path

	// Writes land on the pready cycle
	assign tx_wr = pready && pwrite && addr_ok && (reg_sel == reg_tx_data);

	uart_fifo #(
		.payload_t(uart_byte_t),
		.DEPTH(`UART_TX_DEPTH)
	) tx_fifo (
		.apb(apb),
		.rst(rst),
		.wr(tx_wr),
		.din(pwdata[7:0]),
		.rd(tx_rd),
		.dout(tx_dout),
		.empty(tx_empty),
		.full(tx_full)
	);

	// Drain one byte whenever the serializer is free
	assign tx_rd = !tx_busy && !tx_empty;

	// Start one cycle after the pop, once dout holds the byte
	always_ff @(posedge apb) begin
		if (rst) begin
			tx_busy  <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= tx_rd;
			if (tx_done)
				tx_busy <= 1'b0;
			if (tx_rd)
				tx_busy <= 1'b1;
		end
	end

	uart_tx u_tx (
		.apb(apb),
		.rst(rst),
		.clk_div(clk_div),
		.start(tx_start),
		.data(tx_dout),
		.tx(tx),
		.done(tx_done)
	);

	////////////////////
	// Receive path

	uart_rx u_rx (
		.apb(apb),
		.rst(rst),
		.clk_div(clk_div),
		.rx(rx),
		.valid(rx_valid),
		.entry(rx_entry)
	);

	// Pop in the first access cycle, entry shows at pready
	assign rx_rd = access && !pwrite && addr_ok && (reg_sel == reg_rx_data);

	uart_fifo #(
		.payload_t(rx_entry_t),
		.DEPTH(`UART_RX_DEPTH)
	) rx_fifo (
		.apb(apb),
		.rst(rst),
		.wr(rx_valid),
		.din(rx_entry),
		.rd(rx_rd),
		.dout(rx_dout),
		.empty(rx_empty),
		.full(rx_full)
	);

	////////////////////
	// Control registers

	always_ff @(posedge apb) begin
		if (rst) begin
			clk_div    <= '0;
			overrun    <= 1'b0;
			rx_empty_q <= 1'b0;
		end else begin
			// Empty as seen when the pop was tried
			rx_empty_q <= rx_empty;
			if (pready && pwrite && addr_ok && reg_sel == reg_clk_div)
				clk_div <= pwdata[15:0];
			// STATUS read clears, a new drop in the same cycle wins
			if (pready && !pwrite && addr_ok && reg_sel == reg_status)
				overrun <= 1'b0;
			if (rx_valid && rx_full)
				overrun <= 1'b1;
		end
	end

	////////////////////
	// Read data and errors

	// Both stay zero outside the pready cycle
	always_comb begin
		prdata  = '0;
		pslverr = 1'b0;
		if (pready) begin
			if (!addr_ok) begin
				pslverr = 1'b1;
			end else if (pwrite) begin
				case (reg_sel)
					reg_status:  pslverr = 1'b1;
					reg_rx_data: pslverr = 1'b1;
					// Byte refused when the FIFO is full
					reg_tx_data: pslverr = tx_full;
					default:     pslverr = 1'b0;
				endcase
			end else begin
				case (reg_sel)
					reg_status:  prdata = {29'b0, overrun, !rx_empty, tx_full};
					reg_clk_div: prdata = {16'b0, clk_div};
					reg_tx_data: pslverr = 1'b1;
					default: begin
						pslverr = rx_empty_q;
						if (!rx_empty_q)
							prdata = {{(`UART_DATA_WIDTH - $bits(rx_entry_t)){1'b0}}, rx_dout};
					end
				endcase
			end
		end
	end

endmodule

// File: rtl/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// FIFO depths in entries
`define UART_TX_DEPTH 16
`define UART_RX_DEPTH 16

// APB address bus
// Upper bits must be zero, low two bits ignored
`define UART_ADDR_WIDTH 12

// APB data bus
`define UART_DATA_WIDTH 32

`endif

// File: rtl/uart_fifo.sv
module uart_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 16
) (
	input  logic     apb,
	input  logic     rst,
	input  logic     wr,
	input  payload_t din,
	input  logic     rd,
	output payload_t dout,
	output logic     empty,
	output logic     full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// Flags straight off the occupancy counter
	assign empty = count == '0;
	assign full  = count == CNT_W'(DEPTH);

	// Requests past the limits are dropped
	assign push = wr && !full;
	assign pop  = rd && !empty;

	// Wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		nxt = ptr + 1'b1;
		if (ptr == PTR_W'(DEPTH - 1))
			nxt = '0;
		return nxt;
	endfunction

	always_ff @(posedge apb) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			// Push and pop together keep the count
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Storage and output register
	// dout holds the last popped entry until the next pop
	always_ff @(posedge apb) begin
		if (push)
			mem[wr_ptr] <= din;
		if (pop)
			dout <= mem[rd_ptr];
	end

endmodule

// File: rtl/uart_pkg.sv
package uart_pkg;

	// One character on the line
	typedef logic [7:0] uart_byte_t;

	// RX FIFO entry
	// Bit 8 is the framing error, bits 7 to 0 the byte
	typedef struct packed {
		logic       framing_error;
		uart_byte_t data;
	} rx_entry_t;

	// Register index, taken from paddr bits 3 to 2
	typedef enum logic [1:0] {
		// TX full, RX ready, overrun
		reg_status  = 2'd0,
		// Bit period minus one
		reg_clk_div = 2'd1,
		// Write only, pushes the TX FIFO
		reg_tx_data = 2'd2,
		// Read only, pops the RX FIFO
		reg_rx_data = 2'd3
	} reg_index_t;

endpackage

// File: rtl/uart_rx.sv
module uart_rx (
	input  logic                apb,
	input  logic                rst,
	input  logic [15:0]         clk_div,
	input  logic                rx,
	output logic                valid,
	output uart_pkg::rx_entry_t entry
);

	import uart_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_t;

	logic        rx_meta;
	logic        rx_sync;
	logic        rx_prev;
	rx_state_t   state;
	logic [15:0] cnt;
	logic [2:0]  bit_idx;
	uart_byte_t  shreg;
	logic        sample;

	// Half a period into the start bit, then one full period per bit
	assign sample = (state == st_start) ? (cnt == (clk_div >> 1)) : (cnt == clk_div);

	////////////////////
	// Input synchronizer

	// Preset high so reset does not look like a falling edge
	always_ff @(posedge apb) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	////////////////////
	// Frame FSM

	always_ff @(posedge apb) begin
		if (rst) begin
			state   <= st_idle;
			cnt     <= '0;
			bit_idx <= '0;
			valid   <= 1'b0;
		end else begin
			valid <= 1'b0;
			if (state == st_idle) begin
				cnt <= '0;
				// Falling edge marks a start bit
				if (rx_prev && !rx_sync)
					state <= st_start;
			end else if (!sample) begin
				cnt <= cnt + 1'b1;
			end else begin
				cnt <= '0;
				case (state)
					// High at mid start bit means a glitch
					st_start: begin
						state   <= rx_sync ? st_idle : st_data;
						bit_idx <= '0;
					end
					st_data: begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= st_stop;
					end
					// Entry is out the cycle after mid stop bit
					default: begin
						state <= st_idle;
						valid <= 1'b1;
					end
				endcase
			end
		end
	end

	// Data shifts in from the top, LSB first
	always_ff @(posedge apb) begin
		if (state == st_data && sample)
			shreg <= {rx_sync, shreg[7:1]};
		// Low stop bit flags a framing error
		if (state == st_stop && sample)
			entry <= '{framing_error: !rx_sync, data: shreg};
	end

endmodule

// File: rtl/uart_tx.sv
module uart_tx (
	input  logic                apb,
	input  logic                rst,
	input  logic [15:0]         clk_div,
	input  logic                start,
	input  uart_pkg::uart_byte_t data,
	output logic                tx,
	output logic                done
);

	import uart_pkg::*;

	logic       busy;
	logic [15:0] cnt;
	logic [3:0] bit_idx;
	uart_byte_t shreg;
	logic       bit_end;

	// Last cycle of the current bit
	assign bit_end = cnt == clk_div;

	// Index 9 is the stop bit
	assign done = busy && bit_end && (bit_idx == 4'd9);

	////////////////////
	// Bit timing and line

	always_ff @(posedge apb) begin
		if (rst) begin
			busy    <= 1'b0;
			tx      <= 1'b1;
			cnt     <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			tx <= 1'b1;
			// Start bit goes out on the next cycle
			if (start) begin
				busy    <= 1'b1;
				tx      <= 1'b0;
				cnt     <= '0;
				bit_idx <= '0;
			end
		end else if (bit_end) begin
			cnt <= '0;
			if (bit_idx == 4'd9) begin
				busy <= 1'b0;
				tx   <= 1'b1;
			end else begin
				bit_idx <= bit_idx + 1'b1;
				// LSB first, the ones shifted in give the stop bit
				tx <= shreg[0];
			end
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Shift register, refilled with ones from the top
	always_ff @(posedge apb) begin
		if (!busy && start)
			shreg <= data;
		else if (busy && bit_end && bit_idx != 4'd9)
			shreg <= {1'b1, shreg[7:1]};
	end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f sources.f --top-module apb_uart_tb -o apb_uart_sim

./obj_dir/apb_uart_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Finished with errors" sim.log; then
	exit 1
fi
exit 0

// File: sources.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/apb_uart.sv
verification/apb_uart_properties.sv
verification/apb_uart_tb.sv

// File: verification/apb_uart_properties.sv
`include "uart_cfg.svh"

module apb_uart_properties (
	input logic                        apb,
	input logic                        rst,
	input logic                        psel,
	input logic                        penable,
	input logic                        pready,
	input logic                        pslverr,
	input logic [`UART_DATA_WIDTH-1:0] prdata,
	input logic                        tx
);

	timeunit 1ns;
	timeprecision 100ps;

	// pready lasts one cycle
	pready_single: assert property (@(posedge apb) disable iff (rst) pready |=> !pready)
		else $error("pready high two cycles in a row");

	// Response only in the pready cycle
	resp_quiet: assert property (@(posedge apb) disable iff (rst)
		!pready |-> (pslverr == 1'b0 && prdata == '0))
		else $error("pslverr or prdata nonzero outside pready");

	// Idle line out of reset
	tx_idle_reset: assert property (@(posedge apb) rst |=> tx)
		else $error("tx low after reset");

	// One wait state after the first access cycle
	pready_follows: assert property (@(posedge apb) disable iff (rst)
		$rose(psel && penable) |=> pready)
		else $error("pready missing after access cycle");

	pready_cause: assert property (@(posedge apb) disable iff (rst)
		$rose(pready) |-> $past(psel && penable))
		else $error("pready without an access cycle");

endmodule

bind apb_uart apb_uart_properties i_apb_uart_properties (
	.apb(apb),
	.rst(rst),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.prdata(prdata),
	.tx(tx)
);

// File: verification/apb_uart_tb.sv
`include "uart_cfg.svh"

module apb_uart_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import uart_pkg::*;

	// Working divisor and its bit period
	localparam int DIV = 7;
	localparam int BIT_CYCLES = DIV + 1;
	// Frames at their divisors, plus slack per test
	localparam int TIMEOUT_CYCLES = 10 + 6 * 200
		+ (12 + 2 + `UART_RX_DEPTH + 2) * 10 * BIT_CYCLES
		+ (`UART_TX_DEPTH + 1) * 10 * 201;

	logic                        apb;
	logic                        rst;
	logic                        psel;
	logic                        penable;
	logic                        pwrite;
	logic [`UART_ADDR_WIDTH-1:0] paddr;
	logic [`UART_DATA_WIDTH-1:0] pwdata;
	logic [`UART_DATA_WIDTH-1:0] prdata;
	logic                        pready;
	logic                        pslverr;
	logic                        rx;
	logic                        tx;
	logic                        rx_drv;
	logic                        use_drv;

	logic [31:0] lfsr;
	int          errors;
	int          tests;
	int          tests_failed;
	int          cycles;
	logic [7:0]  sent_q[$];

	// Loopback of tx, or the frame driver
	assign rx = use_drv ? rx_drv : tx;

	apb_uart i_apb_uart (
		.apb(apb),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.rx(rx),
		.tx(tx)
	);

	initial begin
		apb = 1'b0;
		forever #20 apb = ~apb;
	end

	////////////////////
	// Helpers

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return val;
	endfunction

	// Word address of a register
	function automatic logic [`UART_ADDR_WIDTH-1:0] reg_addr(input reg_index_t r);
		return {{(`UART_ADDR_WIDTH - 4){1'b0}}, r, 2'b00};
	endfunction

	task automatic report_error(input string what);
		$display("ERROR t=%0t %s", $time, what);
		errors++;
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		assert (exp === act) else begin
			$display("FAIL t=%0t %s expected %0b got %0b", $time, name, exp, act);
			errors++;
		end
	endtask

	// One transfer, entered and left 2 ns after a rising edge
	task automatic apb_xfer(input logic wr, input logic [`UART_ADDR_WIDTH-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge apb);
		#2;
		penable = 1'b1;
		waits = 0;
		// Sample 1 ns after the edge, outputs settled
		do begin
			@(posedge apb);
			#1;
			waits++;
		end while (!pready && waits < 4);
		rdata = prdata;
		err = pslverr;
		if (!pready)
			report_error("APB transfer got no pready");
		// Hold everything through the pready cycle
		@(posedge apb);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_expect(input logic [`UART_ADDR_WIDTH-1:0] addr,
			input logic [31:0] exp_data, input logic exp_err, input string name);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b0, addr, '0, rdata, err);
		check_val({name, " prdata"}, exp_data, rdata);
		check_bit({name, " pslverr"}, exp_err, err);
	endtask

	task automatic write_expect(input logic [`UART_ADDR_WIDTH-1:0] addr,
			input logic [31:0] data, input logic exp_err, input string name);
		logic [31:0] rdata;
		logic        err;
		apb_xfer(1'b1, addr, data, rdata, err);
		check_bit({name, " pslverr"}, exp_err, err);
	endtask

	// Poll STATUS bit 1
	task automatic wait_rx_ready();
		logic [31:0] rdata;
		logic        err;
		int          polls;
		polls = 0;
		do begin
			apb_xfer(1'b0, reg_addr(reg_status), '0, rdata, err);
			polls++;
		end while (!rdata[1] && polls < 300);
		if (!rdata[1])
			report_error("RX data never became ready");
	endtask

	// 8N1 frame, LSB first, stop bit chosen by the caller
	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		logic [9:0] bits;
		bits = {stop_bit, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx_drv = bits[i];
			repeat (BIT_CYCLES) @(posedge apb);
			#2;
		end
		rx_drv = 1'b1;
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		if (errors == err_start) begin
			$display("Test %s: pass", name);
		end else begin
			tests_failed++;
			$display("Test %s: fail, %0d errors", name, errors - err_start);
		end
	endtask

	////////////////////
	// Tests

	initial begin
		logic [31:0] rdata;
		logic [31:0] val;
		logic        err;
		logic        full;
		logic [7:0]  b;
		int          n;
		int          start;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rx_drv = 1'b1;
		use_drv = 1'b0;
		lfsr = 32'hdfd0_2b4a;
		errors = 0;
		tests = 0;
		tests_failed = 0;
		repeat (10) @(posedge apb);
		#2;
		rst = 1'b0;

		// Registers out of reset
		start = errors;
		read_expect(reg_addr(reg_status), 32'h0, 1'b0, "STATUS");
		read_expect(reg_addr(reg_clk_div), 32'h0, 1'b0, "CLK_DIV");
		end_test("reset state", start);

		// Only the low half of CLK_DIV sticks
		start = errors;
		val = rand_bits(32);
		write_expect(reg_addr(reg_clk_div), val, 1'b0, "CLK_DIV write");
		read_expect(reg_addr(reg_clk_div), {16'h0, val[15:0]}, 1'b0, "CLK_DIV");
		write_expect(reg_addr(reg_clk_div), DIV, 1'b0, "CLK_DIV write");
		read_expect(reg_addr(reg_clk_div), DIV, 1'b0, "CLK_DIV");
		end_test("divisor", start);

		// tx looped back into rx
		start = errors;
		for (int i = 0; i < 12; i++) begin
			b = 8'(rand_bits(8));
			sent_q.push_back(b);
			write_expect(reg_addr(reg_tx_data), {24'h0, b}, 1'b0, "TX_DATA");
		end
		for (int i = 0; i < 12; i++) begin
			wait_rx_ready();
			read_expect(reg_addr(reg_rx_data), {24'h0, sent_q[i]}, 1'b0, "RX_DATA");
		end
		end_test("loopback", start);

		// Bad accesses
		start = errors;
		read_expect(reg_addr(reg_tx_data), 32'h0, 1'b1, "TX_DATA read");
		write_expect(reg_addr(reg_status), 32'h1, 1'b1, "STATUS write");
		write_expect(reg_addr(reg_rx_data), 32'h1, 1'b1, "RX_DATA write");
		read_expect(`UART_ADDR_WIDTH'(16), 32'h0, 1'b1, "unmapped read");
		read_expect(reg_addr(reg_rx_data), 32'h0, 1'b1, "RX_DATA empty");
		// Slow line so the TX FIFO fills, rx off the loopback
		use_drv = 1'b1;
		write_expect(reg_addr(reg_clk_div), 32'd200, 1'b0, "CLK_DIV write");
		n = 0;
		full = 1'b0;
		while (!full && n < 2 * `UART_TX_DEPTH) begin
			write_expect(reg_addr(reg_tx_data), rand_bits(8), 1'b0, "TX_DATA fill");
			apb_xfer(1'b0, reg_addr(reg_status), '0, rdata, err);
			full = rdata[0];
			n++;
		end
		if (!full)
			report_error("TX FIFO never reported full");
		write_expect(reg_addr(reg_tx_data), 32'ha5, 1'b1, "TX_DATA full");
		end_test("error responses", start);

		// Low stop bit, then an idle frame
		start = errors;
		write_expect(reg_addr(reg_clk_div), DIV, 1'b0, "CLK_DIV write");
		b = 8'(rand_bits(8));
		send_frame(b, 1'b0);
		repeat (10 * BIT_CYCLES) @(posedge apb);
		#2;
		wait_rx_ready();
		read_expect(reg_addr(reg_rx_data), {23'h0, 1'b1, b}, 1'b0, "RX_DATA framing");
		end_test("framing error", start);

		// Two frames more than the RX FIFO holds
		start = errors;
		sent_q.delete();
		for (int i = 0; i < `UART_RX_DEPTH + 2; i++) begin
			b = 8'(rand_bits(8));
			sent_q.push_back(b);
			send_frame(b, 1'b1);
		end
		apb_xfer(1'b0, reg_addr(reg_status), '0, rdata, err);
		check_bit("STATUS overrun", 1'b1, rdata[2]);
		// Cleared by the first read
		apb_xfer(1'b0, reg_addr(reg_status), '0, rdata, err);
		check_bit("STATUS overrun", 1'b0, rdata[2]);
		for (int i = 0; i < `UART_RX_DEPTH; i++)
			read_expect(reg_addr(reg_rx_data), {24'h0, sent_q[i]}, 1'b0, "RX_DATA");
		read_expect(reg_addr(reg_rx_data), 32'h0, 1'b1, "RX_DATA after drain");
		end_test("overrun", start);

		$display("Tests run %0d, failed %0d, errors %0d", tests, tests_failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Run limit
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge apb);
			cycles++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycles);
		$display("Finished with errors");
		$finish;
	end

endmodule
